// File: files.f
src/displayPkg.sv
src/frameBuffer.sv
src/frameTimer.sv
src/spiTx.sv
src/displaySequencer.sv
src/displayCtrl.sv
tests/tbDisplayCtrl.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tbDisplayCtrl
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Simulation FAILED
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi; exit $$status

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tests/tbDisplayCtrl.sv
`timescale 1ns/1ps
`default_nettype none

module tbDisplayCtrl
  import displayPkg::*;
();

  // one byte on the wire plus setup and the busy drop
  localparam int BYTE_CYCLES = 8 * 2 * SCK_HALF + 2;
  localparam int INIT_TIME = 2 * RESET_CYCLES + INIT_COUNT * BYTE_CYCLES;
  // both write rounds and their two-frame waits fit in six periods
  localparam int TIMEOUT_CYCLES = 6 * FRAME_CYCLES + INIT_TIME;
  localparam int WRITE_WAIT = 8;

  logic                 clk_i;
  logic                 rstN_i;
  logic                 wrReq_i;
  logic [FB_ADDR_W-1:0] wrAddr_i;
  logic [15:0]          wrData_i;
  logic                 wrAck_o;
  logic                 sdo_o;
  logic                 sck_o;
  logic                 csN_o;
  logic                 dc_o;
  logic                 resN_o;
  logic                 frameStart_o;

  logic [31:0] lfsrState;
  logic [15:0] model [FB_WORDS];
  logic [7:0]  byteQ [$];
  logic        dcQ [$];
  logic [7:0]  shiftByte;
  logic        sckPrev;
  logic        ackPrev;
  logic        reqAtEdge;
  int          bitCount;
  int          bytesInFrame;
  int          framesSeen;
  int          checkCount;
  int          errorCount;
  int          cycleCount;

  displayCtrl i_displayCtrl (
    .clk_i        (clk_i),
    .rstN_i       (rstN_i),
    .wrReq_i      (wrReq_i),
    .wrAddr_i     (wrAddr_i),
    .wrData_i     (wrData_i),
    .wrAck_o      (wrAck_o),
    .sdo_o        (sdo_o),
    .sck_o        (sck_o),
    .csN_o        (csN_o),
    .dc_o         (dc_o),
    .resN_o       (resN_o),
    .frameStart_o (frameStart_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] takeBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsrState = lfsrNext(lfsrState);
      v = {v[30:0], lfsrState[0]};
    end
    return v;
  endfunction

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    checkCount++;
    if (expected !== actual) begin
      errorCount++;
      $display("Error %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
    end
  endtask

  // four-phase write, model follows the host
  task automatic writeWord(input logic [FB_ADDR_W-1:0] addr, input logic [15:0] data);
    int waitCycles;
    waitCycles = 0;
    @(negedge clk_i);
    wrReq_i  = 1'b1;
    wrAddr_i = addr;
    wrData_i = data;
    do begin
      @(negedge clk_i);
      waitCycles++;
    end while (!wrAck_o && waitCycles < WRITE_WAIT);
    checkValue($sformatf("write ack latency addr %0d", addr), 32'd1, 32'(waitCycles));
    wrReq_i     = 1'b0;
    model[addr] = data;
    waitCycles  = 0;
    do begin
      @(negedge clk_i);
      waitCycles++;
    end while (wrAck_o && waitCycles < WRITE_WAIT);
    if (wrAck_o) begin
      errorCount++;
      $display("Write to address %0d: acknowledge never dropped after release", addr);
    end
  endtask

  task automatic waitFrameStart();
    do @(negedge clk_i); while (!frameStart_o);
  endtask

  task automatic waitBytes(input int count);
    while (byteQ.size() < count) @(negedge clk_i);
  endtask

  task automatic checkFrame(input string name, input int startIdx);
    logic [15:0] word;
    for (int k = 0; k < FRAME_BYTES; k++) begin
      word = model[k / 2];
      checkValue($sformatf("%s byte %0d", name, k),
                 32'(k % 2 ? word[15:8] : word[7:0]), 32'(byteQ[startIdx + k]));
      checkValue($sformatf("%s dc %0d", name, k), 32'd1, 32'(dcQ[startIdx + k]));
    end
  endtask

  always @(posedge clk_i) begin
    reqAtEdge <= wrReq_i;
    cycleCount++;
    if (cycleCount >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Checks: %0d, errors: %0d", checkCount, errorCount);
      $display("Simulation FAILED");
      $finish;
    end
  end

  // handshake rules, panel pins during reset, SPI decode and frame lengths
  always @(negedge clk_i) begin
    if (wrAck_o && !ackPrev && !reqAtEdge) begin
      errorCount++;
      $display("Write acknowledge rose without a request");
    end
    if (!wrAck_o && ackPrev && reqAtEdge) begin
      errorCount++;
      $display("Write acknowledge fell while the request was still high");
    end
    ackPrev <= wrAck_o;
    if (!resN_o && (!csN_o || sck_o)) begin
      errorCount++;
      $display("SPI pins active while the panel reset is low");
    end
    if (sck_o && !sckPrev && !csN_o) begin
      shiftByte = {shiftByte[6:0], sdo_o};
      bitCount++;
      if (bitCount == 8) begin
        bitCount = 0;
        bytesInFrame++;
        if (byteQ.size() >= INIT_COUNT && !dc_o) begin
          errorCount++;
          $display("Command byte 0x%0h sent after the init sequence", shiftByte);
        end
        byteQ.push_back(shiftByte);
        dcQ.push_back(dc_o);
      end
    end
    if (csN_o) bitCount = 0;
    if (frameStart_o) begin
      if (framesSeen > 0) checkValue("frame length", FRAME_BYTES, 32'(bytesInFrame));
      bytesInFrame = 0;
      framesSeen++;
    end
    sckPrev = sck_o;
  end

  initial begin
    int resLow;
    int startIdx;
    int written;
    rstN_i = 1'b0;
    wrReq_i = 1'b0;
    wrAddr_i = '0;
    wrData_i = '0;
    lfsrState = 32'ha9ba;
    {sckPrev, ackPrev, reqAtEdge, shiftByte} = '0;
    {bitCount, bytesInFrame, framesSeen} = '0;
    {checkCount, errorCount, cycleCount} = '0;
    repeat (2) @(negedge clk_i);
    rstN_i = 1'b1;
    checkValue("resN after reset", 32'd0, 32'(resN_o));
    checkValue("wrAck after reset", 32'd0, 32'(wrAck_o));
    resLow = 0;
    while (!resN_o) begin
      @(negedge clk_i);
      resLow++;
    end
    checkValue("panel reset low time", RESET_CYCLES, 32'(resLow));

    // first round fills every word
    for (int a = 0; a < FB_WORDS; a++) writeWord(FB_ADDR_W'(a), 16'(takeBits(16)));
    waitBytes(INIT_COUNT);
    for (int i = 0; i < INIT_COUNT; i++) begin
      checkValue($sformatf("init command %0d", i), 32'(INIT_CMDS[i]), 32'(byteQ[i]));
      checkValue($sformatf("init dc %0d", i), 32'd0, 32'(dcQ[i]));
    end
    waitFrameStart();
    waitFrameStart();
    startIdx = byteQ.size();
    waitBytes(startIdx + FRAME_BYTES);
    checkFrame("frame after first writes", startIdx);

    // second round touches a random subset
    written = 0;
    for (int a = 0; a < FB_WORDS; a++) begin
      if (takeBits(1) != 0) begin
        writeWord(FB_ADDR_W'(a), 16'(takeBits(16)));
        written++;
      end
    end
    if (written == 0) writeWord(FB_ADDR_W'(takeBits(FB_ADDR_W)), 16'(takeBits(16)));
    waitFrameStart();
    waitFrameStart();
    startIdx = byteQ.size();
    waitBytes(startIdx + FRAME_BYTES);
    checkFrame("frame after second writes", startIdx);

    // nothing more may follow the last byte of the frame
    repeat (2 * BYTE_CYCLES) @(negedge clk_i);
    checkValue("last frame length", FRAME_BYTES, 32'(bytesInFrame));
    checkValue("frames seen", 32'd4, 32'(framesSeen));

    $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src/displayCtrl.sv
`timescale 1ns/1ps
`default_nettype none

module displayCtrl
  import displayPkg::*;
(
  input  logic                 clk_i,
  input  logic                 rstN_i,

  // host write port
  input  logic                 wrReq_i,
  input  logic [FB_ADDR_W-1:0] wrAddr_i,
  input  logic [15:0]          wrData_i,
  output logic                 wrAck_o,

  // panel pins
  output logic                 sdo_o,
  output logic                 sck_o,
  output logic                 csN_o,
  output logic                 dc_o,
  output logic                 resN_o,

  output logic                 frameStart_o
);

  logic [FB_ADDR_W-1:0] rdAddr;
  logic [15:0]          rdData;
  logic                 frameTick;
  logic                 timerStart;
  logic                 txStart;
  logic [7:0]           txByte;
  logic                 txDc;
  logic                 txBusy;

  frameBuffer i_frameBuffer (
    .clk_i    (clk_i),
    .rstN_i   (rstN_i),
    .wrReq_i  (wrReq_i),
    .wrAddr_i (wrAddr_i),
    .wrData_i (wrData_i),
    .wrAck_o  (wrAck_o),
    .rdAddr_i (rdAddr),
    .rdData_o (rdData)
  );

  frameTimer i_frameTimer (
    .clk_i   (clk_i),
    .rstN_i  (rstN_i),
    .start_i (timerStart),
    .tick_o  (frameTick)
  );

  displaySequencer i_displaySequencer (
    .clk_i        (clk_i),
    .rstN_i       (rstN_i),
    .frameTick_i  (frameTick),
    .timerStart_o (timerStart),
    .txBusy_i     (txBusy),
    .txStart_o    (txStart),
    .txByte_o     (txByte),
    .txDc_o       (txDc),
    .rdAddr_o     (rdAddr),
    .rdData_i     (rdData),
    .resN_o       (resN_o),
    .frameStart_o (frameStart_o)
  );

  spiTx i_spiTx (
    .clk_i   (clk_i),
    .rstN_i  (rstN_i),
    .start_i (txStart),
    .byte_i  (txByte),
    .dc_i    (txDc),
    .busy_o  (txBusy),
    .sdo_o   (sdo_o),
    .sck_o   (sck_o),
    .csN_o   (csN_o),
    .dc_o    (dc_o)
  );

endmodule

`default_nettype wire

// File: src/displaySequencer.sv
`timescale 1ns/1ps
`default_nettype none

module displaySequencer
  import displayPkg::*;
(
  input  logic                 clk_i,
  input  logic                 rstN_i,

  // frame pacing
  input  logic                 frameTick_i,
  output logic                 timerStart_o,

  // byte stream to the SPI transmitter
  input  logic                 txBusy_i,
  output logic                 txStart_o,
  output logic [7:0]           txByte_o,
  output logic                 txDc_o,

  // frame buffer read port
  output logic [FB_ADDR_W-1:0] rdAddr_o,
  input  logic [15:0]          rdData_i,

  output logic                 resN_o,
  output logic                 frameStart_o
);

  typedef enum logic [2:0] {
    StResetLow,
    StResetWait,
    StInit,
    StStream,
    StIdle
  } seqStateT;

  seqStateT              state;
  logic [DELAY_W-1:0]    delayCnt;
  logic [CMD_IDX_W-1:0]  cmdIdx;
  logic [BYTE_IDX_W-1:0] byteIdx;
  logic                  txReady;
  logic                  delayDone;

  // txBusy rises one edge after txStart, so the pulse itself blocks a reissue
  assign txReady   = ~txBusy_i & ~txStart_o;
  assign delayDone = (delayCnt == DELAY_W'(RESET_CYCLES - 1));

  // word of the next byte, valid long before the byte is issued
  assign rdAddr_o = byteIdx[FB_ADDR_W:1];

  always_ff @(posedge clk_i or negedge rstN_i) begin
    if (!rstN_i) begin
      state        <= StResetLow;
      delayCnt     <= '0;
      cmdIdx       <= '0;
      byteIdx      <= '0;
      resN_o       <= 1'b0;
      txStart_o    <= 1'b0;
      txDc_o       <= 1'b0;
      timerStart_o <= 1'b0;
      frameStart_o <= 1'b0;
    end else begin
      // pulses default low
      txStart_o    <= 1'b0;
      timerStart_o <= 1'b0;
      frameStart_o <= 1'b0;

      unique case (state)
        StResetLow: begin
          if (delayDone) begin
            resN_o   <= 1'b1;
            delayCnt <= '0;
            state    <= StResetWait;
          end else begin
            delayCnt <= delayCnt + 1'b1;
          end
        end

        // let the panel come out of reset
        StResetWait: begin
          if (delayDone) begin
            delayCnt <= '0;
            state    <= StInit;
          end else begin
            delayCnt <= delayCnt + 1'b1;
          end
        end

        StInit: begin
          if (txReady) begin
            if (cmdIdx == CMD_IDX_W'(INIT_COUNT)) begin
              // frame 0 follows init directly
              timerStart_o <= 1'b1;
              frameStart_o <= 1'b1;
              state        <= StStream;
            end else begin
              txByte_o  <= INIT_CMDS[cmdIdx];
              txDc_o    <= 1'b0;
              txStart_o <= 1'b1;
              cmdIdx    <= cmdIdx + 1'b1;
            end
          end
        end

        StStream: begin
          if (txReady) begin
            if (byteIdx == BYTE_IDX_W'(FRAME_BYTES)) begin
              // last byte is fully out
              byteIdx <= '0;
              state   <= StIdle;
            end else begin
              // low byte on even index, high byte on odd
              txByte_o  <= byteIdx[0] ? rdData_i[15:8] : rdData_i[7:0];
              txDc_o    <= 1'b1;
              txStart_o <= 1'b1;
              byteIdx   <= byteIdx + 1'b1;
            end
          end
        end

        StIdle: begin
          if (frameTick_i) begin
            frameStart_o <= 1'b1;
            state        <= StStream;
          end
        end

        default: begin
          state <= StResetLow;
        end
      endcase
    end
  end

  txStartWhenIdle: assert property (
    @(posedge clk_i) disable iff (!rstN_i)
    txStart_o |-> !txBusy_i
  );

endmodule

`default_nettype wire

// File: src/spiTx.sv
`timescale 1ns/1ps
`default_nettype none

module spiTx
  import displayPkg::*;
(
  input  logic       clk_i,
  input  logic       rstN_i,

  input  logic       start_i,
  input  logic [7:0] byte_i,
  input  logic       dc_i,
  output logic       busy_o,

  // panel pins
  output logic       sdo_o,
  output logic       sck_o,
  output logic       csN_o,
  output logic       dc_o
);

  logic [7:0]           shiftQ;
  logic [2:0]           bitCnt;
  logic [SCK_DIV_W-1:0] divCnt;
  logic                 load;
  logic                 halfDone;

  assign load     = start_i & ~busy_o;
  assign halfDone = busy_o & (divCnt == '0);

  always_ff @(posedge clk_i or negedge rstN_i) begin
    if (!rstN_i) begin
      busy_o <= 1'b0;
      csN_o  <= 1'b1;
      sck_o  <= 1'b0;
      dc_o   <= 1'b0;
      bitCnt <= '0;
      divCnt <= '0;
    end else if (load) begin
      busy_o <= 1'b1;
      csN_o  <= 1'b0;
      sck_o  <= 1'b0;
      dc_o   <= dc_i;
      bitCnt <= '0;
      // first low half is one cycle longer, that is the setup cycle
      divCnt <= SCK_DIV_W'(SCK_HALF);
    end else if (busy_o) begin
      if (!halfDone) begin
        divCnt <= divCnt - 1'b1;
      end else begin
        divCnt <= SCK_DIV_W'(SCK_HALF - 1);
        if (!sck_o) begin
          // rising edge, panel samples sdo here
          sck_o <= 1'b1;
        end else begin
          sck_o <= 1'b0;
          if (bitCnt == 3'd7) begin
            busy_o <= 1'b0;
            csN_o  <= 1'b1;
          end else begin
            bitCnt <= bitCnt + 1'b1;
          end
        end
      end
    end
  end

  // msb first, next bit shows up on the falling edge
  always_ff @(posedge clk_i) begin
    if (load) begin
      shiftQ <= byte_i;
    end else if (halfDone && sck_o) begin
      shiftQ <= {shiftQ[6:0], 1'b0};
    end
  end

  assign sdo_o = csN_o ? 1'b0 : shiftQ[7];

  // the sequencer must wait for the previous byte
  noStartWhileBusy: assert property (
    @(posedge clk_i) disable iff (!rstN_i)
    start_i |-> !busy_o
  );

endmodule

`default_nettype wire

// File: src/frameTimer.sv
`timescale 1ns/1ps
`default_nettype none

module frameTimer
  import displayPkg::*;
(
  input  logic clk_i,
  input  logic rstN_i,
  input  logic start_i,
  output logic tick_o
);

  logic                   running;
  logic [FRAME_CNT_W-1:0] count;
  logic                   atWrap;

  assign atWrap = (count == FRAME_CNT_W'(FRAME_CYCLES - 1));

  // counter stays parked at zero until the first start
  always_ff @(posedge clk_i or negedge rstN_i) begin
    if (!rstN_i) begin
      running <= 1'b0;
      count   <= '0;
    end else if (start_i) begin
      running <= 1'b1;
      count   <= '0;
    end else if (running) begin
      if (atWrap) begin
        count <= '0;
      end else begin
        count <= count + 1'b1;
      end
    end
  end

  // one pulse per period, at the wrap
  assign tick_o = running & atWrap;

endmodule

`default_nettype wire

// File: src/frameBuffer.sv
`timescale 1ns/1ps
`default_nettype none

module frameBuffer
  import displayPkg::*;
(
  input  logic                 clk_i,
  input  logic                 rstN_i,

  // host write port, four-phase handshake
  input  logic                 wrReq_i,
  input  logic [FB_ADDR_W-1:0] wrAddr_i,
  input  logic [15:0]          wrData_i,
  output logic                 wrAck_o,

  // sequencer read port
  input  logic [FB_ADDR_W-1:0] rdAddr_i,
  output logic [15:0]          rdData_o
);

  logic [15:0] mem [FB_WORDS];
  logic        wrEn;

  // ack mirrors the request one cycle late, so a request that is high
  // while ack is still low is a fresh one
  assign wrEn = wrReq_i & ~wrAck_o;

  always_ff @(posedge clk_i or negedge rstN_i) begin
    if (!rstN_i) begin
      wrAck_o <= 1'b0;
    end else begin
      wrAck_o <= wrReq_i;
    end
  end

  // single write per request, held request does not rewrite
  always_ff @(posedge clk_i) begin
    if (wrEn) begin
      mem[wrAddr_i] <= wrData_i;
    end
  end

  // registered read, data one cycle after address
  always_ff @(posedge clk_i) begin
    rdData_o <= mem[rdAddr_i];
  end

  // ack only ever answers a request seen on the previous edge
  ackNeedsReq: assert property (
    @(posedge clk_i) disable iff (!rstN_i)
    $rose(wrAck_o) |-> $past(wrReq_i)
  );

  // a new request waits until the previous ack has cleared
  newReqAfterAckLow: assert property (
    @(posedge clk_i) disable iff (!rstN_i)
    $rose(wrReq_i) |-> !wrAck_o
  );

endmodule

`default_nettype wire

// File: src/displayPkg.sv
`default_nettype none

package displayPkg;

  // frame buffer geometry
  localparam int FB_WORDS = 16;
  localparam int FB_ADDR_W = 4;

  // two bytes go out per pixel word
  localparam int FRAME_BYTES = 2 * FB_WORDS;
  localparam int BYTE_IDX_W = $clog2(FRAME_BYTES + 1);

  // panel reset low time, reused as the settle time after release
  localparam int RESET_CYCLES = 16;
  localparam int DELAY_W = $clog2(RESET_CYCLES);

  // frame period in clock cycles
  localparam int FRAME_CYCLES = 4000;
  localparam int FRAME_CNT_W = $clog2(FRAME_CYCLES);

  // serial clock half period in clock cycles
  localparam int SCK_HALF = 2;
  // divider also holds SCK_HALF itself for the setup cycle
  localparam int SCK_DIV_W = $clog2(SCK_HALF + 1);

  // init command table
  localparam int INIT_COUNT = 6;
  localparam int CMD_IDX_W = $clog2(INIT_COUNT + 1);

  // display off, remap with its argument, start line with its argument, display on
  localparam logic [7:0] INIT_CMDS [INIT_COUNT] = '{
    8'hAE,
    8'hA0,
    8'h72,
    8'hA1,
    8'h00,
    8'hAF
  };

endpackage

`default_nettype wire
